// File: verilog/rv64_decode_pkg.sv
package rv64_decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN      = 64;  // Integer register width
  localparam int ILEN      = 32;  // Instruction word
  localparam int REG_IDX_W = 5;
  localparam int NUM_XREGS = 32;  // x0 to x31

  ////////////////////////////////////////////////////////////////////////////
  // Function codes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    INVALID = 8'd0,  // No kept encoding matched
    // Upper immediates and jumps
    I_LUI, I_AUIPC, I_JAL, I_JALR,
    // Branches
    I_BEQ, I_BNE, I_BLT, I_BGE, I_BLTU, I_BGEU,
    // Loads
    I_LB, I_LH, I_LW, I_LBU, I_LHU, I_LWU, I_LD,
    // Stores
    I_SB, I_SH, I_SW, I_SD,
    // Register-immediate
    I_ADDI, I_SLTI, I_SLTIU, I_XORI, I_ORI, I_ANDI,
    I_SLLI, I_SRLI, I_SRAI,
    // Register-register
    I_ADD, I_SUB, I_SLL, I_SLT, I_SLTU,
    I_XOR, I_SRL, I_SRA, I_OR, I_AND,
    // 32-bit word forms
    I_ADDIW, I_SLLIW, I_SRLIW, I_SRAIW,
    I_ADDW, I_SUBW, I_SLLW, I_SRLW, I_SRAW,
    // Memory ordering and environment
    I_FENCE, I_FENCE_TSO, I_PAUSE, I_ECALL, I_EBREAK,
    // M extension
    I_MUL, I_MULH, I_MULHSU, I_MULHU,
    I_DIV, I_DIVU, I_REM, I_REMU,
    I_MULW, I_DIVW, I_DIVUW, I_REMW, I_REMUW
  } func_t;

  // Which immediate layout the word carries
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_SHAMT  // Unsigned shift amount
  } imm_kind_t;

  ////////////////////////////////////////////////////////////////////////////
  // Structs between the decode blocks
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic use_rd;
    logic use_rs1;
    logic use_rs2;
  } reg_use_t;

  // Classification of one instruction word
  typedef struct packed {
    func_t     func;
    imm_kind_t imm_kind;
    reg_use_t  reg_use;
    logic      jump;
  } match_info_t;

  // Fetch stage payload
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] code;
  } fetch_t;

  // Output stage payload
  typedef struct packed {
    func_t                func;
    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      pc;
    logic                 jump;     // May redirect the fetch
    logic [NUM_XREGS-1:0] reg_req;  // Registers to be free before issue
  } decoded_instr_t;

endpackage

// File: verilog/rv64_pipe_stage.sv
`timescale 1ns/10ps

module rv64_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,

  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Take a new item when empty or when the held one leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;  // Drain and refill in one edge
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// File: verilog/rv64_opcode_match.sv
`timescale 1ns/10ps

module rv64_opcode_match (
  input  logic [rv64_decode_pkg::ILEN-1:0] code_i,
  output rv64_decode_pkg::match_info_t     info_o
);

  import rv64_decode_pkg::*;

  typedef struct packed {
    logic [ILEN-1:0] mask;
    logic [ILEN-1:0] bits;
    match_info_t     info;
  } entry_t;

  // Field masks
  localparam logic [ILEN-1:0] M_OP  = 32'h0000_007F;  // Opcode only
  localparam logic [ILEN-1:0] M_F3  = 32'h0000_707F;  // Plus funct3
  localparam logic [ILEN-1:0] M_F6  = 32'hFC00_707F;  // RV64 shifts keep shamt[5]
  localparam logic [ILEN-1:0] M_F7  = 32'hFE00_707F;  // Plus funct7
  localparam logic [ILEN-1:0] M_ALL = 32'hFFFF_FFFF;

  // Register use shorthands, rd rs1 rs2
  localparam reg_use_t RU_NONE    = 3'b000;
  localparam reg_use_t RU_RD      = 3'b100;
  localparam reg_use_t RU_RD_RS1  = 3'b110;
  localparam reg_use_t RU_RS1_RS2 = 3'b011;
  localparam reg_use_t RU_ALL     = 3'b111;

  localparam int NUM_ENTRIES = 67;

  ////////////////////////////////////////////////////////////////////////////
  // Encoding table, a later entry wins over an earlier one
  ////////////////////////////////////////////////////////////////////////////

  localparam entry_t MATCH_TABLE [NUM_ENTRIES] = '{
    '{M_OP,  32'h0000_0037, '{I_LUI,       IMM_U,     RU_RD,      1'b0}},
    '{M_OP,  32'h0000_0017, '{I_AUIPC,     IMM_U,     RU_RD,      1'b0}},
    '{M_OP,  32'h0000_006F, '{I_JAL,       IMM_J,     RU_RD,      1'b1}},
    '{M_F3,  32'h0000_0067, '{I_JALR,      IMM_I,     RU_RD_RS1,  1'b1}},
    '{M_F3,  32'h0000_0063, '{I_BEQ,       IMM_B,     RU_RS1_RS2, 1'b1}},
    '{M_F3,  32'h0000_1063, '{I_BNE,       IMM_B,     RU_RS1_RS2, 1'b1}},
    '{M_F3,  32'h0000_4063, '{I_BLT,       IMM_B,     RU_RS1_RS2, 1'b1}},
    '{M_F3,  32'h0000_5063, '{I_BGE,       IMM_B,     RU_RS1_RS2, 1'b1}},
    '{M_F3,  32'h0000_6063, '{I_BLTU,      IMM_B,     RU_RS1_RS2, 1'b1}},
    '{M_F3,  32'h0000_7063, '{I_BGEU,      IMM_B,     RU_RS1_RS2, 1'b1}},
    '{M_F3,  32'h0000_0003, '{I_LB,        IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_1003, '{I_LH,        IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_2003, '{I_LW,        IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_3003, '{I_LD,        IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_4003, '{I_LBU,       IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_5003, '{I_LHU,       IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_6003, '{I_LWU,       IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_0023, '{I_SB,        IMM_S,     RU_RS1_RS2, 1'b0}},
    '{M_F3,  32'h0000_1023, '{I_SH,        IMM_S,     RU_RS1_RS2, 1'b0}},
    '{M_F3,  32'h0000_2023, '{I_SW,        IMM_S,     RU_RS1_RS2, 1'b0}},
    '{M_F3,  32'h0000_3023, '{I_SD,        IMM_S,     RU_RS1_RS2, 1'b0}},
    '{M_F3,  32'h0000_0013, '{I_ADDI,      IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_2013, '{I_SLTI,      IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_3013, '{I_SLTIU,     IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_4013, '{I_XORI,      IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_6013, '{I_ORI,       IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F3,  32'h0000_7013, '{I_ANDI,      IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F6,  32'h0000_1013, '{I_SLLI,      IMM_SHAMT, RU_RD_RS1,  1'b0}},
    '{M_F6,  32'h0000_5013, '{I_SRLI,      IMM_SHAMT, RU_RD_RS1,  1'b0}},
    '{M_F6,  32'h4000_5013, '{I_SRAI,      IMM_SHAMT, RU_RD_RS1,  1'b0}},
    '{M_F7,  32'h0000_0033, '{I_ADD,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h4000_0033, '{I_SUB,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_1033, '{I_SLL,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_2033, '{I_SLT,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_3033, '{I_SLTU,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_4033, '{I_XOR,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_5033, '{I_SRL,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h4000_5033, '{I_SRA,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_6033, '{I_OR,        IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_7033, '{I_AND,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F3,  32'h0000_001B, '{I_ADDIW,     IMM_I,     RU_RD_RS1,  1'b0}},
    '{M_F7,  32'h0000_101B, '{I_SLLIW,     IMM_SHAMT, RU_RD_RS1,  1'b0}},
    '{M_F7,  32'h0000_501B, '{I_SRLIW,     IMM_SHAMT, RU_RD_RS1,  1'b0}},
    '{M_F7,  32'h4000_501B, '{I_SRAIW,     IMM_SHAMT, RU_RD_RS1,  1'b0}},
    '{M_F7,  32'h0000_003B, '{I_ADDW,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h4000_003B, '{I_SUBW,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_103B, '{I_SLLW,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0000_503B, '{I_SRLW,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h4000_503B, '{I_SRAW,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_0033, '{I_MUL,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_1033, '{I_MULH,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_2033, '{I_MULHSU,    IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_3033, '{I_MULHU,     IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_4033, '{I_DIV,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_5033, '{I_DIVU,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_6033, '{I_REM,       IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_7033, '{I_REMU,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_003B, '{I_MULW,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_403B, '{I_DIVW,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_503B, '{I_DIVUW,     IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_603B, '{I_REMW,      IMM_NONE,  RU_ALL,     1'b0}},
    '{M_F7,  32'h0200_703B, '{I_REMUW,     IMM_NONE,  RU_ALL,     1'b0}},
    // Ordering bits ride in the I immediate
    '{M_F3,  32'h0000_000F, '{I_FENCE,     IMM_I,     RU_NONE,    1'b0}},
    '{M_ALL, 32'h8330_000F, '{I_FENCE_TSO, IMM_I,     RU_NONE,    1'b0}},
    '{M_ALL, 32'h0100_000F, '{I_PAUSE,     IMM_I,     RU_NONE,    1'b0}},
    '{M_ALL, 32'h0000_0073, '{I_ECALL,     IMM_NONE,  RU_NONE,    1'b1}},
    '{M_ALL, 32'h0010_0073, '{I_EBREAK,    IMM_NONE,  RU_NONE,    1'b1}}
  };

  always_comb begin
    info_o = '{INVALID, IMM_NONE, RU_NONE, 1'b0};  // Unmatched word
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if ((code_i & MATCH_TABLE[i].mask) == MATCH_TABLE[i].bits) begin
        info_o = MATCH_TABLE[i].info;
      end
    end
  end

endmodule

// File: verilog/rv64_imm_gen.sv
`timescale 1ns/10ps

module rv64_imm_gen (
  input  logic [rv64_decode_pkg::ILEN-1:0] code_i,
  input  rv64_decode_pkg::imm_kind_t       imm_kind_i,
  output logic [rv64_decode_pkg::XLEN-1:0] imm_o
);

  import rv64_decode_pkg::*;

  logic            sign;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_sh;

  assign sign = code_i[31];  // Every signed layout keeps its sign here

  assign imm_i  = {{(XLEN-12){sign}}, code_i[31:20]};
  assign imm_s  = {{(XLEN-12){sign}}, code_i[31:25], code_i[11:7]};
  assign imm_b  = {{(XLEN-12){sign}}, code_i[7], code_i[30:25], code_i[11:8], 1'b0};
  assign imm_u  = {{(XLEN-32){sign}}, code_i[31:12], 12'h000};
  assign imm_j  = {{(XLEN-20){sign}}, code_i[19:12], code_i[20], code_i[30:21], 1'b0};
  assign imm_sh = {{(XLEN-6){1'b0}}, code_i[25:20]};  // Zero extended

  ////////////////////////////////////////////////////////////////////////////
  // Layout select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (imm_kind_i)
      IMM_I:     imm_o = imm_i;
      IMM_S:     imm_o = imm_s;
      IMM_B:     imm_o = imm_b;
      IMM_U:     imm_o = imm_u;
      IMM_J:     imm_o = imm_j;
      IMM_SHAMT: imm_o = imm_sh;
      default:   imm_o = '0;  // No immediate
    endcase
  end

endmodule

// File: verilog/rv64_reg_select.sv
`timescale 1ns/10ps

module rv64_reg_select (
  input  logic [rv64_decode_pkg::ILEN-1:0]      code_i,
  input  rv64_decode_pkg::match_info_t          info_i,
  output logic [rv64_decode_pkg::REG_IDX_W-1:0] rd_o,
  output logic [rv64_decode_pkg::REG_IDX_W-1:0] rs1_o,
  output logic [rv64_decode_pkg::REG_IDX_W-1:0] rs2_o,
  output logic [rv64_decode_pkg::NUM_XREGS-1:0] reg_req_o
);

  import rv64_decode_pkg::*;

  // Unused fields read as x0
  assign rd_o  = info_i.reg_use.use_rd  ? code_i[11:7]  : '0;
  assign rs1_o = info_i.reg_use.use_rs1 ? code_i[19:15] : '0;
  assign rs2_o = info_i.reg_use.use_rs2 ? code_i[24:20] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Requirement vector
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    reg_req_o        = '0;
    reg_req_o[0]     = 1'b1;  // x0 always listed
    reg_req_o[rd_o]  = 1'b1;
    reg_req_o[rs1_o] = 1'b1;
    reg_req_o[rs2_o] = 1'b1;
    // A possible redirect waits on the whole register file
    if (info_i.jump) begin
      reg_req_o = '1;
    end
  end

endmodule

// File: verilog/rv64_decode_top.sv
`timescale 1ns/10ps

module rv64_decode_top (
  input  logic                            clk_i,
  input  logic                            reset_i,

  input  logic                            in_valid_i,
  input  rv64_decode_pkg::fetch_t         in_data_i,
  output logic                            in_ready_o,

  output logic                            out_valid_o,
  output rv64_decode_pkg::decoded_instr_t out_data_o,
  input  logic                            out_ready_i
);

  import rv64_decode_pkg::*;

  logic                 fetch_valid;
  logic                 fetch_ready;
  fetch_t               fetch_data;
  match_info_t          match_info;
  logic [XLEN-1:0]      imm;
  logic [REG_IDX_W-1:0] rd;
  logic [REG_IDX_W-1:0] rs1;
  logic [REG_IDX_W-1:0] rs2;
  logic [NUM_XREGS-1:0] reg_req;
  decoded_instr_t       decoded;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch stage
  ////////////////////////////////////////////////////////////////////////////

  rv64_pipe_stage #(
    .payload_t(fetch_t)
  ) fetch_stage_u (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_data_i  (in_data_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(fetch_valid),
    .out_data_o (fetch_data),
    .out_ready_i(fetch_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Combinational decode
  ////////////////////////////////////////////////////////////////////////////

  rv64_opcode_match opcode_match_u (
    .code_i(fetch_data.code),
    .info_o(match_info)
  );

  rv64_imm_gen imm_gen_u (
    .code_i    (fetch_data.code),
    .imm_kind_i(match_info.imm_kind),
    .imm_o     (imm)
  );

  rv64_reg_select reg_select_u (
    .code_i   (fetch_data.code),
    .info_i   (match_info),
    .rd_o     (rd),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .reg_req_o(reg_req)
  );

  always_comb begin
    decoded.func    = match_info.func;
    decoded.rd      = rd;
    decoded.rs1     = rs1;
    decoded.rs2     = rs2;
    decoded.imm     = imm;
    decoded.pc      = fetch_data.pc;  // Carried from fetch
    decoded.jump    = match_info.jump;
    decoded.reg_req = reg_req;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////////////////////

  rv64_pipe_stage #(
    .payload_t(decoded_instr_t)
  ) out_stage_u (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_valid_i (fetch_valid),
    .in_data_i  (decoded),
    .in_ready_o (fetch_ready),
    .out_valid_o(out_valid_o),
    .out_data_o (out_data_o),
    .out_ready_i(out_ready_i)
  );

endmodule

// File: sim/rv64_decode_ref.svh
// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
    state = {state[30:0], fb};
    r     = {r[30:0], fb};
  end
  return r;
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference decode by opcode, funct3 and funct7
////////////////////////////////////////////////////////////////////////////

function automatic decoded_instr_t ref_decode(input logic [31:0] c, input logic [63:0] pc);
  decoded_instr_t d;
  func_t          f;
  logic           urd;
  logic           urs1;
  logic           urs2;
  int             kind;  // 0 none, 1 I, 2 S, 3 B, 4 U, 5 J, 6 shamt
  logic [2:0]     f3;
  logic [6:0]     f7;
  f3 = c[14:12];
  f7 = c[31:25];
  f = INVALID;
  {urd, urs1, urs2, kind} = '0;
  d = '0;
  d.pc = pc;
  case (c[6:0])
    7'h37: begin
      f    = I_LUI;
      urd  = 1;
      kind = 4;
    end
    7'h17: begin
      f    = I_AUIPC;
      urd  = 1;
      kind = 4;
    end
    7'h6F: begin
      f    = I_JAL;
      urd  = 1;
      kind = 5;
    end
    7'h67: begin
      if (f3 == 0) f = I_JALR;
      {urd, urs1, kind} = {1'b1, 1'b1, 32'd1};
    end
    7'h63: begin
      case (f3)
        0: f = I_BEQ;
        1: f = I_BNE;
        4: f = I_BLT;
        5: f = I_BGE;
        6: f = I_BLTU;
        7: f = I_BGEU;
        default: f = INVALID;
      endcase
      {urs1, urs2, kind} = {1'b1, 1'b1, 32'd3};
    end
    7'h03: begin
      case (f3)
        0: f = I_LB;
        1: f = I_LH;
        2: f = I_LW;
        3: f = I_LD;
        4: f = I_LBU;
        5: f = I_LHU;
        6: f = I_LWU;
        default: f = INVALID;
      endcase
      {urd, urs1, kind} = {1'b1, 1'b1, 32'd1};
    end
    7'h23: begin
      case (f3)
        0: f = I_SB;
        1: f = I_SH;
        2: f = I_SW;
        3: f = I_SD;
        default: f = INVALID;
      endcase
      {urs1, urs2, kind} = {1'b1, 1'b1, 32'd2};
    end
    7'h13: begin
      {urd, urs1, kind} = {1'b1, 1'b1, 32'd1};
      case (f3)
        0: f = I_ADDI;
        2: f = I_SLTI;
        3: f = I_SLTIU;
        4: f = I_XORI;
        6: f = I_ORI;
        7: f = I_ANDI;
        default: f = INVALID;
      endcase
      if (f3 == 1 || f3 == 5) kind = 6;
      if (f3 == 1 && c[31:26] == 6'h00) f = I_SLLI;
      if (f3 == 5 && c[31:26] == 6'h00) f = I_SRLI;
      if (f3 == 5 && c[31:26] == 6'h10) f = I_SRAI;
    end
    7'h33: begin
      {urd, urs1, urs2} = 3'b111;
      if (f7 == 7'h01) f = func_t'(int'(I_MUL) + f3);  // Funct3 order of the M group
      else if (f7 == 7'h20 && f3 == 0) f = I_SUB;
      else if (f7 == 7'h20 && f3 == 5) f = I_SRA;
      else if (f7 == 7'h00) begin
        case (f3)
          0: f = I_ADD;
          1: f = I_SLL;
          2: f = I_SLT;
          3: f = I_SLTU;
          4: f = I_XOR;
          5: f = I_SRL;
          6: f = I_OR;
          default: f = I_AND;
        endcase
      end
    end
    7'h1B: begin
      {urd, urs1} = 2'b11;
      kind = (f3 == 0) ? 1 : 6;
      if (f3 == 0) f = I_ADDIW;
      else if (f3 == 1 && f7 == 7'h00) f = I_SLLIW;
      else if (f3 == 5 && f7 == 7'h00) f = I_SRLIW;
      else if (f3 == 5 && f7 == 7'h20) f = I_SRAIW;
    end
    7'h3B: begin
      {urd, urs1, urs2} = 3'b111;
      case ({f7, f3})
        {7'h00, 3'd0}: f = I_ADDW;
        {7'h00, 3'd1}: f = I_SLLW;
        {7'h00, 3'd5}: f = I_SRLW;
        {7'h20, 3'd0}: f = I_SUBW;
        {7'h20, 3'd5}: f = I_SRAW;
        {7'h01, 3'd0}: f = I_MULW;
        {7'h01, 3'd4}: f = I_DIVW;
        {7'h01, 3'd5}: f = I_DIVUW;
        {7'h01, 3'd6}: f = I_REMW;
        {7'h01, 3'd7}: f = I_REMUW;
        default: f = INVALID;
      endcase
    end
    7'h0F: begin
      kind = 1;
      if (c == 32'h8330_000F) f = I_FENCE_TSO;
      else if (c == 32'h0100_000F) f = I_PAUSE;
      else if (f3 == 0) f = I_FENCE;
    end
    7'h73: begin
      if (c == 32'h0000_0073) f = I_ECALL;
      if (c == 32'h0010_0073) f = I_EBREAK;
    end
    default: f = INVALID;
  endcase
  if (f == INVALID) begin
    {urd, urs1, urs2, kind} = '0;
  end
  d.func = f;
  d.jump = (f == I_JAL || f == I_JALR || f == I_ECALL || f == I_EBREAK
            || c[6:0] == 7'h63 && f != INVALID);
  d.rd  = urd  ? c[11:7]  : 5'd0;
  d.rs1 = urs1 ? c[19:15] : 5'd0;
  d.rs2 = urs2 ? c[24:20] : 5'd0;
  case (kind)
    1: d.imm = {{52{c[31]}}, c[31:20]};
    2: d.imm = {{52{c[31]}}, c[31:25], c[11:7]};
    3: d.imm = {{51{c[31]}}, c[31], c[7], c[30:25], c[11:8], 1'b0};
    4: d.imm = {{32{c[31]}}, c[31:12], 12'h000};
    5: d.imm = {{43{c[31]}}, c[31], c[19:12], c[20], c[30:21], 1'b0};
    6: d.imm = {58'd0, c[25:20]};
    default: d.imm = '0;
  endcase
  d.reg_req = 32'd1 | (32'd1 << d.rd) | (32'd1 << d.rs1) | (32'd1 << d.rs2);
  if (d.jump) d.reg_req = '1;
  return d;
endfunction

////////////////////////////////////////////////////////////////////////////
// Word generators
////////////////////////////////////////////////////////////////////////////

localparam logic [6:0]  KEPT_OPS [11] = '{7'h37, 7'h17, 7'h6F, 7'h67, 7'h63, 7'h03,
                                          7'h23, 7'h13, 7'h33, 7'h1B, 7'h3B};
localparam logic [6:0]  BAD_OPS  [8]  = '{7'h07, 7'h27, 7'h43, 7'h53, 7'h2F, 7'h73,
                                          7'h0B, 7'h7F};
localparam logic [31:0] FULL_WORDS [4] = '{32'h0000_0073, 32'h0010_0073,
                                           32'h8330_000F, 32'h0100_000F};

function automatic logic [31:0] gen_legal();
  logic [31:0] w;
  w = take_bits(stim_lfsr, 32);
  w[6:0] = KEPT_OPS[take_bits(stim_lfsr, 4) % 11];
  case (take_bits(stim_lfsr, 2))
    0: w[31:25] = 7'h00;
    1: w[31:25] = 7'h20;
    2: w[31:25] = 7'h01;
    default: ;  // Keep random upper bits
  endcase
  if (take_bits(stim_lfsr, 3) == 0) w = FULL_WORDS[take_bits(stim_lfsr, 2)];
  if (take_bits(stim_lfsr, 4) == 0) w = {17'd0, 3'd0, 5'd0, 7'h0F} | (w & 32'h0FF0_0000);
  return w;
endfunction

function automatic logic [31:0] gen_illegal();
  logic [31:0] w;
  w = take_bits(stim_lfsr, 32);
  w[6:0] = BAD_OPS[take_bits(stim_lfsr, 3)];
  if (w[6:0] == 7'h73) w[12] = 1'b1;  // CSR access
  return w;
endfunction

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_instr(input string name, input decoded_instr_t exp_v,
                           input decoded_instr_t act_v);
  if (exp_v !== act_v) begin
    errors++;
    $display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
  end
endtask

task automatic check_func(input string name, input func_t exp_v, input func_t act_v);
  if (exp_v !== act_v) begin
    errors++;
    $display("[FAIL] %s func expected %s actual %s", name, exp_v.name(), act_v.name());
  end
endtask

task automatic check_flag(input string name, input logic exp_v, input logic act_v);
  if (exp_v !== act_v) begin
    errors++;
    $display("[FAIL] %s expected %b actual %b", name, exp_v, act_v);
  end
endtask

// File: sim/rv64_decode_tb.sv
`timescale 1ns/10ps

module rv64_decode_tb;

  import rv64_decode_pkg::*;

  localparam int          NUM_LEGAL      = 300;
  localparam int          NUM_ILLEGAL    = 60;
  localparam int          NUM_MIXED      = 160;
  localparam int          NUM_INSTR      = 1 + NUM_LEGAL + NUM_ILLEGAL + NUM_MIXED;
  localparam logic [31:0] SEED           = 32'h6f5b;
  localparam int          TIMEOUT_MARGIN = 200;
  localparam int          CLK_PERIOD     = 20;

  logic           clk_i = 1'b0;
  logic           reset_i;
  logic           in_valid_i;
  fetch_t         in_data_i;
  logic           in_ready_o;
  logic           out_valid_o;
  decoded_instr_t out_data_o;
  logic           out_ready_i;

  logic [31:0]    stim_lfsr;
  logic [31:0]    ready_lfsr;
  logic           stall_mode;  // Random out_ready_i when set
  logic [63:0]    next_pc;
  decoded_instr_t exp_q[$];
  decoded_instr_t held;
  logic           held_valid;
  int             errors;
  int             acc_cnt;
  int             rx_cnt;
  string          test_name;

  `include "rv64_decode_ref.svh"

  rv64_decode_top dut_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_data_i  (in_data_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(out_valid_o),
    .out_data_o (out_data_o),
    .out_ready_i(out_ready_i)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #((NUM_INSTR * 4 + TIMEOUT_MARGIN) * CLK_PERIOD);
    $display("Timeout: %0d of %0d instructions came out", rx_cnt, acc_cnt);
    $display("TEST FAILED");
    $finish;
  end

  always @(negedge clk_i) begin
    if (stall_mode) begin
      out_ready_i = (take_bits(ready_lfsr, 1) != 0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : compare_outputs
    decoded_instr_t expected;
    if (!reset_i) begin
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(ref_decode(in_data_i.code, in_data_i.pc));
        acc_cnt++;
      end
      if (held_valid) begin
        check_flag("valid held while stalled", 1'b1, out_valid_o);
        check_instr("hold while stalled", held, out_data_o);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Output transfer with no instruction outstanding");
        end else begin
          expected = exp_q.pop_front();
          check_func(test_name, expected.func, out_data_o.func);
          check_instr(test_name, expected, out_data_o);
        end
        rx_cnt++;
        held_valid = 1'b0;
      end else if (out_valid_o) begin
        held       = out_data_o;
        held_valid = 1'b1;
      end
    end
  end

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_word(input logic [31:0] code);
    int n;
    n = acc_cnt;
    in_valid_i     = 1'b1;
    in_data_i.pc   = next_pc;
    in_data_i.code = code;
    do @(negedge clk_i); while (acc_cnt == n);
    in_valid_i = 1'b0;
    next_pc    = next_pc + 64'd4;
  endtask

  initial begin
    stim_lfsr   = SEED;
    ready_lfsr  = SEED;
    stall_mode  = 1'b0;
    next_pc     = 64'h0000_0000_8000_0000;
    held        = '0;
    held_valid  = 1'b0;
    {errors, acc_cnt, rx_cnt} = '0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;  // Sink stalled through reset
    reset_i     = 1'b1;
    test_name   = "reset";
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    check_flag("reset out_valid_o", 1'b0, out_valid_o);
    check_flag("reset in_ready_o", 1'b1, in_ready_o);

    test_name      = "latency";
    out_ready_i    = 1'b1;
    in_valid_i     = 1'b1;
    in_data_i.pc   = next_pc;
    in_data_i.code = 32'h0000_0013;
    @(negedge clk_i);  // Accepted on edge N
    check_flag("latency accepted", 1'b1, acc_cnt == 1);
    check_flag("latency after edge N", 1'b0, out_valid_o);
    in_valid_i = 1'b0;
    next_pc    = next_pc + 64'd4;
    @(negedge clk_i);
    check_flag("latency after edge N+1", 1'b1, out_valid_o);
    @(negedge clk_i);

    test_name = "legal stream";
    repeat (NUM_LEGAL) send_word(gen_legal());
    test_name = "illegal words";
    repeat (NUM_ILLEGAL) send_word(gen_illegal());

    test_name = "back-pressure";
    @(posedge clk_i);
    stall_mode = 1'b1;  // Sink turns random from the next falling edge
    @(negedge clk_i);
    repeat (NUM_MIXED) begin
      if (take_bits(stim_lfsr, 1) != 0) @(negedge clk_i);
      send_word((take_bits(stim_lfsr, 2) != 0) ? gen_legal() : gen_illegal());
    end
    while (rx_cnt != acc_cnt) @(negedge clk_i);
    @(posedge clk_i);
    stall_mode = 1'b0;
    @(negedge clk_i);
    out_ready_i = 1'b1;
    repeat (4) @(negedge clk_i);
    check_flag("drained out_valid_o", 1'b0, out_valid_o);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d instructions never came out", exp_q.size());
    end

    $display("Errors: %0d, instructions checked: %0d", errors, rx_cnt);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+sim
verilog/rv64_decode_pkg.sv
verilog/rv64_pipe_stage.sv
verilog/rv64_opcode_match.sv
verilog/rv64_imm_gen.sv
verilog/rv64_reg_select.sv
verilog/rv64_decode_top.sv
sim/rv64_decode_tb.sv

// File: Makefile
SRCS := $(shell grep -v '^+' vlog.f) sim/rv64_decode_ref.svh

.PHONY: run clean

run: obj_dir/Vrv64_decode_tb
	@out=$$(./obj_dir/Vrv64_decode_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

obj_dir/Vrv64_decode_tb: vlog.f $(SRCS)
	verilator --binary --timing --top-module rv64_decode_tb -f vlog.f -o Vrv64_decode_tb

clean:
	rm -rf obj_dir
